/* src.f */
+incdir+source
source/assoc_pkg.sv
source/plru_tree.sv
source/fill_ctrl.sv
source/way_entry.sv
source/hit_select.sv
source/assoc_table.sv
testbench/assoc_table_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the assoc_table testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  --top-module assoc_table_tb \
  -f src.f \
  -Mdir obj_dir \
  -o assoc_table_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/assoc_table_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
  echo "no result found in sim.log"
  exit 1
fi
exit 0

/* testbench/assoc_table_tb.sv */
`timescale 1ns/10ps

`include "assoc_consts.svh"

module assoc_table_tb;

  import assoc_pkg::*;

  localparam int  RANDOM_OPS  = 1500;
  localparam int  STIM_CYCLES = RANDOM_OPS + 300;
  localparam time TIMEOUT     = STIM_CYCLES * 4 * 4 + 2000;

  logic     clk;
  logic     rst;
  logic     lookup;
  tag_t     lookup_tag;
  logic     fill;
  tag_t     fill_tag;
  payload_t fill_data;

  logic     result_valid;
  logic     hit;
  way_idx_t hit_way;
  payload_t hit_data;
  way_idx_t victim_way;
  way_idx_t last_fill_way;

  // model tree in heap order with children of n at 2n+1 and 2n+2
  logic        m_valid [`ASSOC_WAYS];
  tag_t        m_tag   [`ASSOC_WAYS];
  payload_t    m_data  [`ASSOC_WAYS];
  logic [14:0] m_tree;
  logic        exp_rv;
  logic        exp_hit;
  way_idx_t    exp_way;
  payload_t    exp_data;
  way_idx_t    exp_last_fill;

  int error_count;
  int check_count;

  assoc_table uut (
    .clk           (clk),
    .rst           (rst),
    .lookup        (lookup),
    .lookup_tag    (lookup_tag),
    .fill          (fill),
    .fill_tag      (fill_tag),
    .fill_data     (fill_data),
    .result_valid  (result_valid),
    .hit           (hit),
    .hit_way       (hit_way),
    .hit_data      (hit_data),
    .victim_way    (victim_way),
    .last_fill_way (last_fill_way)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // walk from the root where 0 picks the lower half
  function automatic way_idx_t victim_of(input logic [14:0] tree);
    int       n;
    way_idx_t w;
    n = 0;
    w = '0;
    for (int l = 3; l >= 0; l--) begin
      w[l] = tree[n];
      n = 2 * n + 1 + int'(tree[n]);
    end
    return w;
  endfunction

  function automatic logic [14:0] away_from(input logic [14:0] tree, input way_idx_t w);
    int          n;
    logic [14:0] t;
    n = 0;
    t = tree;
    for (int l = 3; l >= 0; l--) begin
      t[n] = ~w[l];
      n = 2 * n + 1 + int'(w[l]);
    end
    return t;
  endfunction

  // {hit, way, payload} for a tag
  function automatic logic [28:0] lookup_ref(input tag_t t);
    logic [28:0] r;
    r = '0;
    for (int i = 0; i < `ASSOC_WAYS; i++) begin
      if (m_valid[i] && m_tag[i] == t) begin
        r = {1'b1, 4'(i), m_data[i]};
      end
    end
    return r;
  endfunction

  function automatic logic tag_present(input tag_t t);
    logic [28:0] r;
    r = lookup_ref(t);
    return r[28];
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("[FAIL] %0t ns: %s got %0h expected %0h", $time, what, got, expected);
    end
  endtask

  // compare at negedge and step the model with the inputs of the next posedge
  always @(negedge clk) begin
    logic [28:0] res;
    logic        touch;
    logic        any_free;
    way_idx_t    touched;
    way_idx_t    target;
    if (rst) begin
      for (int i = 0; i < `ASSOC_WAYS; i++) begin
        m_valid[i] = 1'b0;
      end
      m_tree        = '0;
      exp_rv        = 1'b0;
      exp_hit       = 1'b0;
      exp_way       = '0;
      exp_data      = '0;
      exp_last_fill = '0;
    end else begin
      check_value(32'(result_valid), 32'(exp_rv), "result_valid");
      if (exp_rv) begin
        check_value(32'(hit), 32'(exp_hit), "hit");
        if (exp_hit) begin
          check_value(32'(hit_way), 32'(exp_way), "hit_way");
          check_value(32'(hit_data), 32'(exp_data), "hit_data");
        end
      end
      check_value(32'(victim_way), 32'(victim_of(m_tree)), "victim_way");
      check_value(32'(last_fill_way), 32'(exp_last_fill), "last_fill_way");

      touch    = exp_rv && exp_hit;
      touched  = exp_way;
      any_free = 1'b1;
      if (lookup) begin
        res      = lookup_ref(lookup_tag);
        exp_hit  = res[28];
        exp_way  = res[27:24];
        exp_data = res[23:0];
      end
      exp_rv = lookup;
      target = victim_of(m_tree);
      if (fill) begin
        any_free = 1'b0;
        for (int i = 0; i < `ASSOC_WAYS; i++) begin
          if (!any_free && !m_valid[i]) begin  // first free way from the bottom
            any_free = 1'b1;
            target   = 4'(i);
          end
        end
        m_valid[target] = 1'b1;
        m_tag[target]   = fill_tag;
        m_data[target]  = fill_data;
        exp_last_fill   = target;
      end
      if (touch) begin  // touch wins over new
        m_tree = away_from(m_tree, touched);
      end else if (fill && !any_free) begin
        m_tree = away_from(m_tree, victim_of(m_tree));
      end
    end
  end

  task automatic drive_cycle(input logic lk, input tag_t ltag, input logic fl,
                             input tag_t ftag, input payload_t fdata);
    @(posedge clk);
    lookup     <= lk;
    lookup_tag <= ltag;
    fill       <= fl;
    fill_tag   <= ftag;
    fill_data  <= fdata;
  endtask

  task automatic idle(input int n);
    repeat (n) drive_cycle(1'b0, '0, 1'b0, '0, '0);
  endtask

  task automatic do_lookup(input tag_t t);
    drive_cycle(1'b1, t, 1'b0, '0, '0);
  endtask

  task automatic do_fill(input tag_t t, input payload_t d);
    drive_cycle(1'b0, '0, 1'b1, t, d);
  endtask

  function automatic tag_t fresh_tag();
    tag_t t;
    t = tag_t'($urandom);
    while (tag_present(t)) begin
      t = tag_t'($urandom);
    end
    return t;
  endfunction

  function automatic tag_t present_tag();
    way_idx_t w;
    w = way_idx_t'($urandom);
    while (!m_valid[w]) begin
      w = way_idx_t'($urandom);
    end
    return m_tag[w];
  endfunction

  initial begin
    tag_t old_tag;
    tag_t new_tag;
    int   r;
    void'($urandom(32'h7ad2));
    error_count = 0;
    check_count = 0;
    rst        = 1'b1;
    lookup     = 1'b0;
    lookup_tag = '0;
    fill       = 1'b0;
    fill_tag   = '0;
    fill_data  = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // every lookup misses on the empty table
    repeat (20) do_lookup(tag_t'($urandom));
    idle(2);
    @(negedge clk);
    check_value(32'(victim_way), 32'h0, "victim_way after reset");

    // fill ways 0..15 in order and hit each
    for (int i = 0; i < `ASSOC_WAYS; i++) begin
      do_fill(20'ha0000 | 20'(i), payload_t'($urandom));
    end
    idle(2);
    for (int i = 0; i < `ASSOC_WAYS; i++) begin
      do_lookup(20'ha0000 | 20'(i));
    end
    idle(2);

    // hits steer the tree of the full table before each replacement
    for (int k = 0; k < 8; k++) begin
      repeat (3) do_lookup(present_tag());
      idle(2);
      old_tag = m_tag[victim_of(m_tree)];
      new_tag = fresh_tag();
      do_fill(new_tag, payload_t'($urandom));
      idle(2);
      do_lookup(old_tag);  // evicted tag must miss
      do_lookup(new_tag);
      idle(2);
    end

    // fill lands in the touch cycle of a hit
    for (int k = 0; k < 6; k++) begin
      do_lookup(present_tag());
      new_tag = fresh_tag();
      do_fill(new_tag, payload_t'($urandom));
      idle(2);
      do_lookup(new_tag);  // entry written despite the lost tree update
      idle(2);
    end

    for (int k = 0; k < RANDOM_OPS; k++) begin
      r = int'($urandom % 5);
      if (r < 2) begin
        do_lookup(present_tag());
      end else if (r == 2) begin
        do_lookup(tag_t'($urandom));
      end else if (r == 3) begin
        do_fill(fresh_tag(), payload_t'($urandom));
      end else begin
        idle(1);
      end
    end
    idle(4);

    $display("errors: %0d of %0d checks", error_count, check_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT);
    $display("timeout: the stimulus did not finish in time");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* source/assoc_table.sv */
`timescale 1ns/10ps

`include "assoc_consts.svh"

// 16-entry fully associative table with tree PLRU replacement
module assoc_table (
  input  logic                clk,
  input  logic                rst,

  input  logic                lookup,
  input  assoc_pkg::tag_t     lookup_tag,

  input  logic                fill,
  input  assoc_pkg::tag_t     fill_tag,
  input  assoc_pkg::payload_t fill_data,

  output logic                result_valid,
  output logic                hit,
  output assoc_pkg::way_idx_t hit_way,
  output assoc_pkg::payload_t hit_data,

  output assoc_pkg::way_idx_t victim_way,
  output assoc_pkg::way_idx_t last_fill_way
);

  import assoc_pkg::*;

  way_mask_t write_en;
  way_mask_t valid_mask;
  way_mask_t match_mask;
  payload_t  way_data [`ASSOC_WAYS];

  logic      lru_new;
  logic      lru_touch;
  way_idx_t  lru_touched;

  fill_ctrl u_fill_ctrl (
    .clk        (clk),
    .rst        (rst),
    .fill       (fill),
    .valid_mask (valid_mask),
    .lru_way    (victim_way),
    .write_en   (write_en),
    .lru_new    (lru_new),
    .fill_way   (last_fill_way)
  );

  for (genvar i = 0; i < `ASSOC_WAYS; i++) begin : g_way
    way_entry #(
      .payload_type (payload_t)
    ) u_way (
      .clk        (clk),
      .rst        (rst),
      .write_en   (write_en[i]),
      .fill_tag   (fill_tag),
      .fill_data  (fill_data),
      .lookup_tag (lookup_tag),
      .valid      (valid_mask[i]),
      .match      (match_mask[i]),
      .data       (way_data[i])
    );
  end

  hit_select #(
    .payload_type (payload_t)
  ) u_hit_select (
    .clk          (clk),
    .rst          (rst),
    .lookup       (lookup),
    .match_mask   (match_mask),
    .way_data     (way_data),
    .result_valid (result_valid),
    .hit          (hit),
    .hit_way      (hit_way),
    .hit_data     (hit_data),
    .lru_touch    (lru_touch),
    .lru_touched  (lru_touched)
  );

  plru_tree u_plru_tree (
    .clk         (clk),
    .rst         (rst),
    .lru_touch   (lru_touch),
    .lru_touched (lru_touched),
    .lru_new     (lru_new),
    .lru_way     (victim_way)  // victim is combinational from tree state
  );

endmodule

/* source/hit_select.sv */
`timescale 1ns/10ps

`include "assoc_consts.svh"

// turns the match mask into the registered lookup result
module hit_select #(
  parameter type payload_type = assoc_pkg::payload_t
) (
  input  logic                 clk,
  input  logic                 rst,

  input  logic                 lookup,
  input  assoc_pkg::way_mask_t match_mask,
  input  payload_type          way_data [`ASSOC_WAYS],

  output logic                 result_valid,
  output logic                 hit,
  output assoc_pkg::way_idx_t  hit_way,
  output payload_type          hit_data,

  output logic                 lru_touch,
  output assoc_pkg::way_idx_t  lru_touched
);

  import assoc_pkg::*;

  way_idx_t match_way;

  // mask is one-hot since tags are unique
  always_comb begin
    match_way = '0;
    for (int i = 0; i < `ASSOC_WAYS; i++) begin
      if (match_mask[i]) begin
        match_way = way_idx_t'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
      hit          <= 1'b0;
    end else begin
      result_valid <= lookup;  // one cycle pulse
      if (lookup) begin
        hit <= |match_mask;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lookup) begin
      hit_way  <= match_way;
      hit_data <= way_data[match_way];
    end
  end

  assign lru_touch   = result_valid & hit;
  assign lru_touched = hit_way;

endmodule

/* source/way_entry.sv */
`timescale 1ns/10ps

// single table entry with its own tag compare
module way_entry #(
  parameter type payload_type = assoc_pkg::payload_t
) (
  input  logic            clk,
  input  logic            rst,

  input  logic            write_en,
  input  assoc_pkg::tag_t fill_tag,
  input  payload_type     fill_data,
  input  assoc_pkg::tag_t lookup_tag,

  output logic            valid,
  output logic            match,
  output payload_type     data
);

  import assoc_pkg::*;

  tag_t tag;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else if (write_en) begin
      valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (write_en) begin
      tag  <= fill_tag;
      data <= fill_data;
    end
  end

  assign match = valid && (tag == lookup_tag);

endmodule

/* source/fill_ctrl.sv */
`timescale 1ns/10ps

`include "assoc_consts.svh"

// picks the fill target and raises the per-way write enable
module fill_ctrl (
  input  logic                 clk,
  input  logic                 rst,

  input  logic                 fill,
  input  assoc_pkg::way_mask_t valid_mask,
  input  assoc_pkg::way_idx_t  lru_way,

  output assoc_pkg::way_mask_t write_en,
  output logic                 lru_new,
  output assoc_pkg::way_idx_t  fill_way
);

  import assoc_pkg::*;

  way_idx_t free_way;
  way_idx_t target_way;
  logic     any_free;

  assign any_free = ~(&valid_mask);

  // lowest invalid way wins
  always_comb begin
    free_way = '0;
    for (int i = `ASSOC_WAYS - 1; i >= 0; i--) begin
      if (!valid_mask[i]) begin
        free_way = way_idx_t'(i);
      end
    end
  end

  assign target_way = any_free ? free_way : lru_way;

  always_comb begin
    write_en = '0;
    if (fill) begin
      write_en[target_way] = 1'b1;
    end
  end

  // tree only moves when a valid entry gets replaced
  assign lru_new = fill & ~any_free;

  always_ff @(posedge clk) begin
    if (rst) begin
      fill_way <= '0;
    end else if (fill) begin
      fill_way <= target_way;
    end
  end

endmodule

/* source/plru_tree.sv */
`timescale 1ns/10ps

// 16-way tree pseudo-LRU
// node bit 0 points to the lower half, 1 to the upper half
// levels: node0 (root), node1 (2), node2 (4), node3 (8 leaves pairs)
module plru_tree (
  input  logic                clk,
  input  logic                rst,

  input  logic                lru_touch,
  input  assoc_pkg::way_idx_t lru_touched,
  input  logic                lru_new,

  output assoc_pkg::way_idx_t lru_way
);

  import assoc_pkg::*;

  logic [0:0]  node0;
  logic [1:0]  node1;
  logic [3:0]  node2;
  logic [7:0]  node3;

  logic [14:0] nodes;
  logic [14:0] touch_next;
  logic [14:0] new_next;

  // flat view: node0 at bit 0, node1 at 2:1, node2 at 6:3, node3 at 14:7
  assign nodes = {node3, node2, node1, node0};

  // every node on the path of w is turned to point away from w
  function automatic logic [14:0] point_away(input logic [14:0] cur, input way_idx_t w);
    logic [14:0] nxt;
    nxt = cur;
    nxt[0]            = ~w[3];
    nxt[1 + w[3]]     = ~w[2];
    nxt[3 + w[3:2]]   = ~w[1];
    nxt[7 + w[3:1]]   = ~w[0];
    return nxt;
  endfunction

  // victim walk, msb of the way first
  always_comb begin
    lru_way    = '0;
    lru_way[3] = node0[0];
    lru_way[2] = node1[lru_way[3]];
    lru_way[1] = node2[lru_way[3:2]];
    lru_way[0] = node3[lru_way[3:1]];
  end

  always_comb begin
    touch_next = point_away(nodes, lru_touched);
  end

  // new flips the victim path, same as touching the victim
  always_comb begin
    new_next = point_away(nodes, lru_way);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      node0 <= '0;
      node1 <= '0;
      node2 <= '0;
      node3 <= '0;
    end else if (lru_touch) begin  // touch beats new
      node0 <= touch_next[0:0];
      node1 <= touch_next[2:1];
      node2 <= touch_next[6:3];
      node3 <= touch_next[14:7];
    end else if (lru_new) begin
      node0 <= new_next[0:0];
      node1 <= new_next[2:1];
      node2 <= new_next[6:3];
      node3 <= new_next[14:7];
    end
  end

endmodule

/* source/assoc_pkg.sv */
package assoc_pkg;

  `include "assoc_consts.svh"

  // way number, 0 .. ASSOC_WAYS-1
  typedef logic [`ASSOC_WAY_BITS-1:0] way_idx_t;

  // one bit per way
  typedef logic [`ASSOC_WAYS-1:0] way_mask_t;

  // lookup / fill key
  typedef logic [`ASSOC_TAG_BITS-1:0] tag_t;

  // data stored with each tag
  typedef logic [`ASSOC_PAYLOAD_BITS-1:0] payload_t;

endpackage

/* source/assoc_consts.svh */
`ifndef ASSOC_CONSTS_SVH
`define ASSOC_CONSTS_SVH

// table geometry
`define ASSOC_WAYS         16
`define ASSOC_WAY_BITS     4

// entry fields
`define ASSOC_TAG_BITS     20
`define ASSOC_PAYLOAD_BITS 24

`endif
